// ==== design/mem_map_pkg.sv ====
package mem_map_pkg;

    //////////////////////////////////////////////////
    // bus widths

    // data word
    typedef logic [31:0] word_t;
    // word address from the pipeline
    typedef logic [29:0] waddr_t;
    // address bits 29..26
    typedef logic [3:0]  region_t;
    typedef logic [3:0]  byte_en_t;
    // character or scancode
    typedef logic [7:0]  char_t;

    //////////////////////////////////////////////////
    // region map

    // text memory behind the display
    localparam region_t REGION_TEXT   = 4'hc;
    // timer region, only the trap window is decoded
    localparam region_t REGION_TIMER  = 4'hd;
    // keyboard scancode queue
    localparam region_t REGION_KEY    = 4'he;
    // loader word memory, also the fetch space
    localparam region_t REGION_LOADER = 4'hf;

    // address bits 25..18 inside the timer region
    localparam logic [7:0] TRAP_TAG = 8'hdd;

    //////////////////////////////////////////////////
    // text writer states

    typedef enum logic [1:0] {
        TEXT_IDLE,
        TEXT_WRITE1,
        TEXT_WRITE2,
        TEXT_SPIN
    } text_state_t;

endpackage

// ==== design/access_router.sv ====
module access_router import mem_map_pkg::*; #(
    parameter int TEXT_AW = 15
) (
    // pipeline data side
    input  logic               dmem_read,
    input  logic               dmem_write,
    input  waddr_t             dmem_addr,
    input  byte_en_t           dmem_byte_en,
    input  word_t              dmem_wdata,
    // pipeline fetch side
    input  waddr_t             instr_addr,
    output word_t              instr_data,
    output word_t              dmem_rdata,
    output logic               mem_stall,
    output logic               trap_stall,
    // loader memory
    output byte_en_t           ld_wen,
    input  word_t              ld_rdata,
    input  word_t              ld_idata,
    // text memory
    output logic               text_write,
    output logic [TEXT_AW-1:0] text_addr,
    output char_t              text_char,
    input  logic               text_stall,
    // keyboard queue
    output logic               key_pop,
    input  char_t              key_head,
    input  logic               key_stall
);

    region_t     d_region;
    region_t     i_region;
    logic        d_access;
    logic        is_one_hot;
    logic [1:0]  lane_bit;
    logic [1:0]  text_off;

    assign d_region = dmem_addr[29:26];
    assign i_region = instr_addr[29:26];
    assign d_access = dmem_read | dmem_write;

    //////////////////////////////////////////////////
    // byte-lane steering

    // index b of a one-hot enable, anything else counts as b = 3
    always_comb begin
        is_one_hot = 1'b1;
        lane_bit   = 2'd3;
        case (dmem_byte_en)
            4'b0001: lane_bit = 2'd0;
            4'b0010: lane_bit = 2'd1;
            4'b0100: lane_bit = 2'd2;
            4'b1000: lane_bit = 2'd3;
            default: is_one_hot = 1'b0;
        endcase
    end

    // text byte offset is b itself, the character sits in lane 3-b
    assign text_off  = lane_bit;
    assign text_addr = {dmem_addr[TEXT_AW-3:0], text_off};

    always_comb begin
        case (lane_bit)
            2'd0:    text_char = dmem_wdata[31:24];
            2'd1:    text_char = dmem_wdata[23:16];
            2'd2:    text_char = dmem_wdata[15:8];
            default: text_char = dmem_wdata[7:0];
        endcase
    end

    //////////////////////////////////////////////////
    // data side decode

    always_comb begin
        ld_wen     = '0;
        text_write = 1'b0;
        key_pop    = 1'b0;
        trap_stall = 1'b0;
        dmem_rdata = '0;
        case (d_region)
            REGION_LOADER: begin
                dmem_rdata = ld_rdata;
                if (dmem_write) begin
                    if (is_one_hot) begin
                        ld_wen[2'd3 - lane_bit] = 1'b1;
                    end else begin
                        ld_wen = 4'b1111;
                    end
                end
            end
            REGION_TEXT: begin
                text_write = dmem_write;
            end
            REGION_KEY: begin
                key_pop    = dmem_read;
                dmem_rdata = {24'd0, key_head};
            end
            REGION_TIMER: begin
                // trap window holds the pipeline until the access goes away
                if (dmem_addr[25:18] == TRAP_TAG) begin
                    trap_stall = d_access;
                end
            end
            default: begin
                // unmapped, reads zero
                dmem_rdata = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // fetch side and stall merge

    assign instr_data = (i_region == REGION_LOADER) ? ld_idata : '0;

    assign mem_stall = text_stall | key_stall | trap_stall;

endmodule

// ==== design/loader_mem.sv ====
module loader_mem import mem_map_pkg::*; #(
    parameter int LOADER_AW = 10
) (
    input  logic                 clk_pipeline,
    // port a, data read and write
    input  logic [LOADER_AW-1:0] a_addr,
    input  byte_en_t             a_wen,
    input  word_t                a_wdata,
    output word_t                a_rdata,
    // port b, fetch only
    input  logic [LOADER_AW-1:0] b_addr,
    output word_t                b_rdata
);

    localparam int DEPTH = 2 ** LOADER_AW;

    word_t mem [DEPTH];

    //////////////////////////////////////////////////
    // port a

    // lane k covers bits 8k+7..8k
    always_ff @(posedge clk_pipeline) begin
        for (int k = 0; k < 4; k++) begin
            if (a_wen[k]) begin
                mem[a_addr][k*8 +: 8] <= a_wdata[k*8 +: 8];
            end
        end
    end

    // registered read, old data on a write edge
    always_ff @(posedge clk_pipeline) begin
        a_rdata <= mem[a_addr];
    end

    //////////////////////////////////////////////////
    // port b

    always_ff @(posedge clk_pipeline) begin
        b_rdata <= mem[b_addr];
    end

endmodule

// ==== design/text_mem_port.sv ====
module text_mem_port import mem_map_pkg::*; #(
    parameter int TEXT_AW = 15
) (
    input  logic               clk_pipeline,
    input  logic               rst,
    // pipeline side
    input  logic               text_write,
    input  logic [TEXT_AW-1:0] text_addr,
    input  char_t              text_char,
    output logic               text_stall,
    // display side
    input  logic [TEXT_AW-1:0] disp_addr,
    output char_t              disp_char
);

    localparam int DEPTH = 2 ** TEXT_AW;

    char_t       text_ram [DEPTH];
    text_state_t state;
    text_state_t state_next;
    logic        store;

    //////////////////////////////////////////////////
    // write window FSM

    // byte goes in on the entry edge, address and char are held by the pipeline
    assign store = (state == TEXT_IDLE) && text_write;

    always_comb begin
        state_next = state;
        case (state)
            TEXT_IDLE: begin
                if (text_write) begin
                    state_next = TEXT_WRITE1;
                end
            end
            TEXT_WRITE1: state_next = TEXT_WRITE2;
            TEXT_WRITE2: state_next = TEXT_SPIN;
            TEXT_SPIN: begin
                // wait here until the pipeline drops the access
                if (!text_write) begin
                    state_next = TEXT_IDLE;
                end
            end
            default: state_next = TEXT_IDLE;
        endcase
    end

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            state <= TEXT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // high in idle, write1 and write2, so three cycles per write
    assign text_stall = text_write && (state != TEXT_SPIN);

    //////////////////////////////////////////////////
    // character store

    always_ff @(posedge clk_pipeline) begin
        if (store) begin
            text_ram[text_addr] <= text_char;
        end
    end

    // display read, one cycle behind disp_addr
    always_ff @(posedge clk_pipeline) begin
        disp_char <= text_ram[disp_addr];
    end

endmodule

// ==== design/key_queue.sv ====
module key_queue import mem_map_pkg::*; #(
    parameter int KEY_DEPTH_LOG2 = 3
) (
    input  logic  clk_pipeline,
    input  logic  rst,
    // keyboard side, no back-pressure
    input  logic  key_strobe,
    input  char_t key_code,
    // cpu side
    input  logic  key_pop,
    output char_t key_head,
    output logic  key_stall,
    output logic  key_ready,
    output logic  key_overflow
);

    localparam int DEPTH = 2 ** KEY_DEPTH_LOG2;

    char_t                   queue [DEPTH];
    // one extra bit tells full from empty
    logic [KEY_DEPTH_LOG2:0] wr_ptr;
    logic [KEY_DEPTH_LOG2:0] rd_ptr;
    logic                    empty;
    logic                    full;
    logic                    do_pop;
    logic                    do_push;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[KEY_DEPTH_LOG2] != rd_ptr[KEY_DEPTH_LOG2])
                && (wr_ptr[KEY_DEPTH_LOG2-1:0] == rd_ptr[KEY_DEPTH_LOG2-1:0]);

    assign do_pop  = key_pop && !empty;
    // a pop on the same edge frees the slot being written
    assign do_push = key_strobe && (!full || do_pop);

    //////////////////////////////////////////////////
    // pointers and flags

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            key_overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky, only reset clears it
            if (key_strobe && !do_push) begin
                key_overflow <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // storage

    always_ff @(posedge clk_pipeline) begin
        if (do_push) begin
            queue[wr_ptr[KEY_DEPTH_LOG2-1:0]] <= key_code;
        end
    end

    assign key_head  = queue[rd_ptr[KEY_DEPTH_LOG2-1:0]];
    assign key_ready = !empty;
    // cpu read on an empty queue waits for the next strobe
    assign key_stall = key_pop && empty;

endmodule

// ==== design/mem_router.sv ====
module mem_router import mem_map_pkg::*; #(
    parameter int LOADER_AW      = 10,
    parameter int TEXT_AW        = 15,
    parameter int KEY_DEPTH_LOG2 = 3
) (
    input  logic               clk_pipeline,
    input  logic               rst,
    // fetch side
    input  waddr_t             instr_addr,
    output word_t              instr_data,
    // data side
    input  logic               dmem_read,
    input  logic               dmem_write,
    input  waddr_t             dmem_addr,
    input  byte_en_t           dmem_byte_en,
    input  word_t              dmem_wdata,
    output word_t              dmem_rdata,
    output logic               mem_stall,
    output logic               trap_stall,
    // keyboard
    input  logic               key_strobe,
    input  char_t              key_code,
    output logic               key_ready,
    output logic               key_overflow,
    // display
    input  logic [TEXT_AW-1:0] disp_addr,
    output char_t              disp_char
);

    byte_en_t           ld_wen;
    word_t              ld_rdata;
    word_t              ld_idata;
    logic               text_write;
    logic [TEXT_AW-1:0] text_addr;
    char_t              text_char;
    logic               text_stall;
    logic               key_pop;
    char_t              key_head;
    logic               key_stall;

    //////////////////////////////////////////////////
    // decode and steering

    access_router #(
        .TEXT_AW      (TEXT_AW)
    ) u_access_router (
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_addr    (dmem_addr),
        .dmem_byte_en (dmem_byte_en),
        .dmem_wdata   (dmem_wdata),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .dmem_rdata   (dmem_rdata),
        .mem_stall    (mem_stall),
        .trap_stall   (trap_stall),
        .ld_wen       (ld_wen),
        .ld_rdata     (ld_rdata),
        .ld_idata     (ld_idata),
        .text_write   (text_write),
        .text_addr    (text_addr),
        .text_char    (text_char),
        .text_stall   (text_stall),
        .key_pop      (key_pop),
        .key_head     (key_head),
        .key_stall    (key_stall)
    );

    //////////////////////////////////////////////////
    // peripherals

    // low word-address bits index the loader memory
    loader_mem #(
        .LOADER_AW    (LOADER_AW)
    ) u_loader_mem (
        .clk_pipeline (clk_pipeline),
        .a_addr       (dmem_addr[LOADER_AW-1:0]),
        .a_wen        (ld_wen),
        .a_wdata      (dmem_wdata),
        .a_rdata      (ld_rdata),
        .b_addr       (instr_addr[LOADER_AW-1:0]),
        .b_rdata      (ld_idata)
    );

    text_mem_port #(
        .TEXT_AW      (TEXT_AW)
    ) u_text_mem_port (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .text_write   (text_write),
        .text_addr    (text_addr),
        .text_char    (text_char),
        .text_stall   (text_stall),
        .disp_addr    (disp_addr),
        .disp_char    (disp_char)
    );

    key_queue #(
        .KEY_DEPTH_LOG2 (KEY_DEPTH_LOG2)
    ) u_key_queue (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .key_strobe   (key_strobe),
        .key_code     (key_code),
        .key_pop      (key_pop),
        .key_head     (key_head),
        .key_stall    (key_stall),
        .key_ready    (key_ready),
        .key_overflow (key_overflow)
    );

endmodule

// ==== bench/clock_gen.sv ====
module clock_gen (
    output logic clk_pipeline,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;

    initial begin
        clk_pipeline = 1'b0;
        forever #5 clk_pipeline = ~clk_pipeline;
    end

    // released on a falling edge, after 8 rising edges in reset
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_pipeline);
        @(negedge clk_pipeline);
        rst = 1'b1;
    end
endmodule

// ==== bench/mem_router_asserts.sv ====
module mem_router_asserts (
    input logic clk_pipeline,
    input logic rst,
    input logic text_stall,
    input logic key_strobe,
    input logic key_stall,
    input logic key_ready,
    input logic key_overflow,
    input logic mem_stall
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // each text write holds the pipeline for three rising edges
    text_window: assert property (@(posedge clk_pipeline) disable iff (!rst)
        $rose(text_stall) |-> text_stall ##1 text_stall ##1 text_stall ##1 !text_stall)
    else begin
        fail_count++;
        $error("text stall window is not three cycles long");
    end

    // a read on an empty queue, only a strobe makes it ready on the next cycle
    key_flags: assert property (@(posedge clk_pipeline) disable iff (!rst)
        key_stall |-> !key_ready ##1 (key_ready == $past(key_strobe)))
    else begin
        fail_count++;
        $error("key_ready does not follow the strobe during a key stall");
    end

    reset_idle: assert property (@(posedge clk_pipeline)
        $rose(rst) |-> !mem_stall && !key_ready && !key_overflow)
    else begin
        fail_count++;
        $error("stall or queue flags high right after reset");
    end
endmodule

bind mem_router mem_router_asserts u_asserts (
    .clk_pipeline (clk_pipeline),
    .rst          (rst),
    .text_stall   (text_stall),
    .key_strobe   (key_strobe),
    .key_stall    (key_stall),
    .key_ready    (key_ready),
    .key_overflow (key_overflow),
    .mem_stall    (mem_stall)
);

// ==== bench/tb_mem_router.sv ====
module tb_mem_router import mem_map_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LOADER_AW = 10;
    localparam int TEXT_AW   = 15;
    localparam int KEY_LOG2  = 3;
    localparam int KEY_DEPTH = 2 ** KEY_LOG2;
    localparam int NUM_WORDS = 6;
    localparam waddr_t KEY_ADDR  = {REGION_KEY, 26'd0};
    localparam waddr_t TRAP_ADDR = {REGION_TIMER, TRAP_TAG, 18'h0};

    // cycle estimate per test, then a margin on top
    localparam int LOADER_CYC = NUM_WORDS * 6 + 4 * 6;
    localparam int FETCH_CYC  = NUM_WORDS * 2 + 4;
    localparam int TEXT_CYC   = 4 * 8;
    localparam int KEY_CYC    = 3 * 4 + 12 + (KEY_DEPTH + 1) * 4;
    localparam int TRAP_CYC   = 12;
    localparam int WATCHDOG_NS =
        (8 + LOADER_CYC + FETCH_CYC + TEXT_CYC + KEY_CYC + TRAP_CYC + 100) * 10;

    logic clk_pipeline, rst;
    waddr_t instr_addr, dmem_addr;
    word_t instr_data, dmem_wdata, dmem_rdata;
    logic dmem_read, dmem_write, mem_stall, trap_stall;
    byte_en_t dmem_byte_en;
    logic key_strobe, key_ready, key_overflow;
    char_t key_code, disp_char;
    logic [TEXT_AW-1:0] disp_addr;

    int     error_count;
    int     assert_count;
    integer seed;
    waddr_t word_addr [NUM_WORDS];
    word_t  word_data [NUM_WORDS];

    clock_gen u_clock_gen (.clk_pipeline(clk_pipeline), .rst(rst));

    mem_router #(
        .LOADER_AW(LOADER_AW), .TEXT_AW(TEXT_AW), .KEY_DEPTH_LOG2(KEY_LOG2)
    ) dut (.*);

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    // held until the first rising edge with mem_stall low
    task automatic bus_access(input logic rd, input logic wr, input waddr_t addr,
                              input byte_en_t be, input word_t wdata, output int stalls,
                              output word_t rdata_now, output word_t rdata_late);
        stalls = 0;
        @(negedge clk_pipeline);
        dmem_read    = rd;
        dmem_write   = wr;
        dmem_addr    = addr;
        dmem_byte_en = be;
        dmem_wdata   = wdata;
        #1;
        while (mem_stall) begin
            stalls++;
            @(negedge clk_pipeline);
            #1;
        end
        rdata_now = dmem_rdata;
        @(negedge clk_pipeline);
        // registered loader data, address still held
        rdata_late = dmem_rdata;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
    endtask

    task automatic check_loader();
        int    stalls;
        word_t now_d, late_d, bytes, expect_w;
        for (int i = 0; i < NUM_WORDS; i++) begin
            word_addr[i] = {REGION_LOADER, 16'd0, i[2:0], 7'($random(seed))};
            word_data[i] = $random(seed);
            bus_access(1'b0, 1'b1, word_addr[i], 4'b1111, word_data[i], stalls, now_d, late_d);
            if (stalls != 0) report_mismatch("mem_stall cycles", stalls, 0);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            bus_access(1'b1, 1'b0, word_addr[i], 4'b1111, '0, stalls, now_d, late_d);
            if (late_d !== word_data[i]) report_mismatch("dmem_rdata", late_d, word_data[i]);
        end
        // enable bit b may only touch lane 3-b
        for (int b = 0; b < 4; b++) begin
            bytes = $random(seed);
            expect_w = word_data[0];
            expect_w[(3-b)*8 +: 8] = bytes[(3-b)*8 +: 8];
            word_data[0] = expect_w;
            bus_access(1'b0, 1'b1, word_addr[0], 4'b0001 << b, bytes, stalls, now_d, late_d);
            bus_access(1'b1, 1'b0, word_addr[0], 4'b1111, '0, stalls, now_d, late_d);
            if (late_d !== expect_w) report_mismatch("dmem_rdata", late_d, expect_w);
        end
    endtask

    task automatic check_fetch();
        for (int i = 0; i < NUM_WORDS; i++) begin
            @(negedge clk_pipeline);
            instr_addr = word_addr[i];
            @(negedge clk_pipeline);
            if (instr_data !== word_data[i]) begin
                report_mismatch("instr_data", instr_data, word_data[i]);
            end
        end
        instr_addr = {4'h3, word_addr[0][25:0]};
        @(negedge clk_pipeline);
        @(negedge clk_pipeline);
        if (instr_data !== '0) report_mismatch("instr_data", instr_data, '0);
    endtask

    task automatic check_text();
        int     stalls;
        word_t  chars, now_d, late_d;
        waddr_t taddr;
        for (int b = 0; b < 4; b++) begin
            chars = $random(seed);
            taddr = {REGION_TEXT, 13'd0, 13'($random(seed))};
            bus_access(1'b0, 1'b1, taddr, 4'b0001 << b, chars, stalls, now_d, late_d);
            if (stalls != 3) report_mismatch("mem_stall cycles", stalls, 3);
            @(negedge clk_pipeline);
            disp_addr = {taddr[12:0], 2'(b)};
            @(negedge clk_pipeline);
            if (disp_char !== chars[(3-b)*8 +: 8]) begin
                report_mismatch("disp_char", {24'd0, disp_char}, {24'd0, chars[(3-b)*8 +: 8]});
            end
        end
    endtask

    task automatic check_key_order();
        int    stalls;
        word_t now_d, late_d;
        char_t codes [3];
        char_t late_code;
        @(negedge clk_pipeline);
        for (int i = 0; i < 3; i++) begin
            codes[i]   = 8'($random(seed));
            key_code   = codes[i];
            key_strobe = 1'b1;
            @(negedge clk_pipeline);
        end
        key_strobe = 1'b0;
        for (int i = 0; i < 3; i++) begin
            bus_access(1'b1, 1'b0, KEY_ADDR, 4'b1111, '0, stalls, now_d, late_d);
            if (stalls != 0) report_mismatch("mem_stall cycles", stalls, 0);
            if (now_d !== {24'd0, codes[i]}) begin
                report_mismatch("dmem_rdata", now_d, {24'd0, codes[i]});
            end
        end
        // empty queue, the read waits for the strobe on the fifth falling edge
        late_code = 8'($random(seed));
        fork
            bus_access(1'b1, 1'b0, KEY_ADDR, 4'b1111, '0, stalls, now_d, late_d);
            begin
                repeat (5) @(negedge clk_pipeline);
                key_code   = late_code;
                key_strobe = 1'b1;
                @(negedge clk_pipeline);
                key_strobe = 1'b0;
            end
        join
        if (stalls != 5) report_mismatch("mem_stall cycles", stalls, 5);
        if (now_d !== {24'd0, late_code}) begin
            report_mismatch("dmem_rdata", now_d, {24'd0, late_code});
        end
    endtask

    task automatic check_key_overflow();
        int    stalls;
        word_t now_d, late_d;
        char_t codes [KEY_DEPTH + 1];
        if (key_overflow !== 1'b0) report_mismatch("key_overflow", {31'd0, key_overflow}, 0);
        @(negedge clk_pipeline);
        for (int i = 0; i <= KEY_DEPTH; i++) begin
            codes[i]   = 8'($random(seed));
            key_code   = codes[i];
            key_strobe = 1'b1;
            @(negedge clk_pipeline);
        end
        key_strobe = 1'b0;
        if (key_overflow !== 1'b1) report_mismatch("key_overflow", {31'd0, key_overflow}, 1);
        for (int i = 0; i < KEY_DEPTH; i++) begin
            bus_access(1'b1, 1'b0, KEY_ADDR, 4'b1111, '0, stalls, now_d, late_d);
            if (now_d !== {24'd0, codes[i]}) begin
                report_mismatch("dmem_rdata", now_d, {24'd0, codes[i]});
            end
        end
        // the extra code must be gone once the queue is drained
        if (key_ready !== 1'b0) report_mismatch("key_ready", {31'd0, key_ready}, 0);
    endtask

    task automatic check_trap_unmapped();
        int    stalls;
        word_t now_d, late_d;
        @(negedge clk_pipeline);
        dmem_read = 1'b1;
        dmem_addr = TRAP_ADDR;
        repeat (6) begin
            #1;
            if (mem_stall !== 1'b1) report_mismatch("mem_stall", {31'd0, mem_stall}, 1);
            if (trap_stall !== 1'b1) report_mismatch("trap_stall", {31'd0, trap_stall}, 1);
            @(negedge clk_pipeline);
        end
        dmem_read = 1'b0;
        #1;
        if (mem_stall !== 1'b0) report_mismatch("mem_stall", {31'd0, mem_stall}, 0);
        if (trap_stall !== 1'b0) report_mismatch("trap_stall", {31'd0, trap_stall}, 0);
        bus_access(1'b1, 1'b0, {4'h3, 26'h155}, 4'b1111, '0, stalls, now_d, late_d);
        if (stalls != 0) report_mismatch("mem_stall cycles", stalls, 0);
        if (late_d !== '0) report_mismatch("dmem_rdata", late_d, '0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR watchdog expired at %0t, a test never finished", $time);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed = 32'h288ea799;
        error_count = 0;
        {dmem_read, dmem_write, key_strobe} = 3'b000;
        {instr_addr, dmem_addr, dmem_wdata, dmem_byte_en} = '0;
        key_code  = '0;
        disp_addr = '0;
        @(posedge rst);
        check_loader();
        check_fetch();
        check_text();
        check_key_order();
        check_key_overflow();
        check_trap_unmapped();
        repeat (2) @(negedge clk_pipeline);
        assert_count = dut.u_asserts.fail_count;
        $display("check errors %0d, assertion failures %0d", error_count, assert_count);
        if (error_count == 0 && assert_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end
endmodule

// ==== all.f ====
design/mem_map_pkg.sv
design/access_router.sv
design/loader_mem.sv
design/text_mem_port.sv
design/key_queue.sv
design/mem_router.sv
bench/clock_gen.sv
bench/mem_router_asserts.sv
bench/tb_mem_router.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run tb_mem_router with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mem_router -f all.f \
    -o sim_mem_router > build.log 2>&1 &&
./obj_dir/sim_mem_router +verilator+error+limit+100 > sim.log 2>&1 ||
echo "build or simulation ended abnormally, see build.log and sim.log"
grep -qx "NO ERRORS" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
